// ==== filelist.f ====
verilog/pokeyRegPkg.sv
verilog/pokeyIoPkg.sv
verilog/keypadScanner.sv
verilog/potScanner.sv
verilog/triggerLatch.sv
verilog/irqStatus.sv
verilog/pokeyControllerTop.sv
sim/pokeyControllerChecker.sv
sim/pokeyControllerTb.sv

// ==== Bender.yml ====
package:
  name: pokey_controller

sources:
  - verilog/pokeyRegPkg.sv
  - verilog/pokeyIoPkg.sv
  - verilog/keypadScanner.sv
  - verilog/potScanner.sv
  - verilog/triggerLatch.sv
  - verilog/irqStatus.sv
  - verilog/pokeyControllerTop.sv
  - target: simulation
    files:
      - sim/pokeyControllerChecker.sv
      - sim/pokeyControllerTb.sv

// ==== sim/pokeyControllerTb.sv ====
`timescale 1ns/1ps

module pokeyControllerTb;

    localparam logic [3:0] KReset   = 4'd0;
    localparam logic [3:0] KKey     = 4'd1;
    localparam logic [3:0] KTrig    = 4'd2;
    localparam logic [3:0] KIrq     = 4'd3;
    localparam logic [3:0] KPotFast = 4'd4;
    localparam logic [3:0] KPotSlow = 4'd5;
    localparam int NumRows   = 28;
    localparam int ClkPeriod = 20;
    localparam int PotMax    = pokeyIoPkg::PotMax;
    localparam int TickDiv   = pokeyIoPkg::PotTickDiv;
    localparam int RowCycles = (PotMax + 2) * TickDiv + 4096;  // slow scan plus margin

    typedef struct packed {
        logic [3:0] kind;
        logic [7:0] arg;
        logic [7:0] irqen;
        logic [7:0] expA;
        logic [7:0] expB;
    } rowT;

    // kind, arg, irqen, expA, expB
    // key rows take {top0, position} in arg and expect kbcode and skstat
    // trigger rows take {latch, bot1, bot0} and irq rows {top1, tim4, tim2, tim1}
    // pot rows name the pots that never rise and derive counts from rise times
    rowT stimTable [NumRows] = '{
        {KReset, 8'h00, 8'h00, 8'h00, 8'h01},
        {KKey, 8'h00, 8'h40, 8'hC0, 8'h01}, {KKey, 8'h01, 8'h40, 8'hC6, 8'h01},
        {KKey, 8'h02, 8'h40, 8'hC4, 8'h01}, {KKey, 8'h03, 8'h40, 8'hC2, 8'h01},
        {KKey, 8'h04, 8'h40, 8'hD8, 8'h01}, {KKey, 8'h05, 8'h40, 8'hDE, 8'h01},
        {KKey, 8'h06, 8'h40, 8'hDC, 8'h01}, {KKey, 8'h07, 8'h40, 8'hDA, 8'h01},
        {KKey, 8'h08, 8'h40, 8'hD0, 8'h01}, {KKey, 8'h09, 8'h40, 8'hD6, 8'h01},
        {KKey, 8'h0A, 8'h40, 8'hD4, 8'h01}, {KKey, 8'h0B, 8'h40, 8'hD2, 8'h01},
        {KKey, 8'h0C, 8'h40, 8'hC8, 8'h01}, {KKey, 8'h0D, 8'h40, 8'hCE, 8'h01},
        {KKey, 8'h0E, 8'h40, 8'hCC, 8'h01}, {KKey, 8'h0F, 8'h40, 8'hCA, 8'h01},
        {KKey, 8'h1F, 8'h40, 8'h0A, 8'h09},     // top0 held with key F
        {KTrig, 8'h01, 8'h00, 8'h00, 8'h01},
        {KTrig, 8'h02, 8'h00, 8'h01, 8'h00},
        {KTrig, 8'h07, 8'h00, 8'h00, 8'h00},    // latched and read after release
        {KIrq, 8'h01, 8'h01, 8'hFE, 8'h00},
        {KIrq, 8'h80, 8'h80, 8'h7F, 8'h00},
        {KIrq, 8'h87, 8'h87, 8'h78, 8'h00},
        {KIrq, 8'h87, 8'h00, 8'hFF, 8'h00},     // all masked
        {KPotFast, 8'h08, 8'h00, 8'h00, 8'h00},
        {KPotFast, 8'h00, 8'h00, 8'h00, 8'h00},
        {KPotSlow, 8'h00, 8'h00, 8'h00, 8'h00}
    };

    logic                  clk179 = 1'b0;
    logic                  arstN;
    pokeyRegPkg::ctrlRegsT regs;
    logic                  potGo;
    logic [2:0]            timerEvt;
    logic [3:0]            keyInModel;
    logic [3:0]            sideButL;
    logic [3:0]            potIn;
    logic                  keyHeld;
    logic [3:0]            keyPos;
    wire pokeyIoPkg::padInT    padIn;
    wire pokeyIoPkg::padOutT   padOut;
    wire pokeyRegPkg::readBusT readBus;
    wire                   irqL;

    assign padIn = {keyInModel, sideButL, potIn};

    always #(ClkPeriod / 2) clk179 = ~clk179;

    // keypad switch shorts its row to its column
    always_comb begin
        keyInModel = 4'hF;
        if (keyHeld && !padOut.keyDriveL[keyPos[3:2]]) begin
            keyInModel[keyPos[1:0]] = 1'b0;
        end
    end

    pokeyControllerTop u_pokeyControllerTop (
        .clk179  (clk179),
        .arstN   (arstN),
        .regs    (regs),
        .padIn   (padIn),
        .potGo   (potGo),
        .timerEvt(timerEvt),
        .padOut  (padOut),
        .readBus (readBus),
        .irqL    (irqL)
    );

    pokeyControllerChecker u_pokeyControllerChecker (
        .clk179 (clk179),
        .arstN  (arstN),
        .padOut (padOut),
        .readBus(readBus),
        .irqL   (irqL)
    );

    function automatic string rowName(input logic [3:0] kind);
        case (kind)
            KReset:   return "reset";
            KKey:     return "keypad";
            KTrig:    return "trigger";
            KIrq:     return "interrupt";
            KPotFast: return "pot fast";
            default:  return "pot slow";
        endcase
    endfunction

    task automatic waitForIrq(input int maxCycles, output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < maxCycles && !seen; n++) begin
            @(negedge clk179);
            seen = !irqL;
        end
    endtask

    task automatic pressKey(input rowT row);
        logic seen;
        @(negedge clk179);
        regs.irqen  = row.irqen;
        keyPos      = row.arg[3:0];
        keyHeld     = 1'b1;
        sideButL[3] = !row.arg[4];      // top0
        waitForIrq(3 * 16 * pokeyIoPkg::KeyScanDiv, seen);
        if (!seen) begin
            u_pokeyControllerChecker.reportStall("key interrupt never arrived");
        end
        u_pokeyControllerChecker.verifyKeypad(row.expA, row.expB);
        u_pokeyControllerChecker.irqstEquals(~row.irqen);
        @(negedge clk179);
        regs.irqen = 8'h00;
        if (row.arg[4]) begin
            keyHeld  = 1'b0;
            sideButL = 4'hF;
        end
        @(negedge clk179);
        u_pokeyControllerChecker.irqstEquals(8'hFF);    // masked bit reads 1 again
    endtask

    task automatic exerciseTriggers(input rowT row);
        @(negedge clk179);
        regs.gractl[pokeyRegPkg::GractlTrigLatch] = row.arg[2];
        sideButL[2] = !row.arg[0];      // bot0
        sideButL[0] = !row.arg[1];      // bot1
        @(negedge clk179);
        if (row.arg[2]) begin
            sideButL = 4'hF;
            @(negedge clk179);
        end
        u_pokeyControllerChecker.matchTriggers(row.expA, row.expB);
        sideButL    = 4'hF;
        regs.gractl = 8'h00;
        @(negedge clk179);
        u_pokeyControllerChecker.matchTriggers(8'h01, 8'h01);
    endtask

    task automatic fireIrqSources(input rowT row);
        logic seen;
        @(negedge clk179);
        regs.irqen  = row.irqen;
        timerEvt    = row.arg[2:0];
        sideButL[1] = !row.arg[7];      // top1 as break
        @(negedge clk179);
        timerEvt = 3'b000;
        sideButL = 4'hF;
        if (row.expA != 8'hFF) begin
            waitForIrq(8, seen);
            if (!seen) begin
                u_pokeyControllerChecker.reportStall("interrupt output never went low");
            end
        end else begin
            repeat (2) @(negedge clk179);   // cleared one cycle after the edge
        end
        u_pokeyControllerChecker.irqstEquals(row.expA);
        @(negedge clk179);
        regs.irqen = 8'h00;
        @(negedge clk179);
        u_pokeyControllerChecker.irqstEquals(8'hFF);
    endtask

    task automatic scanPots(input rowT row);
        int rise [4];
        int lo [4];
        int hi [4];
        int span;
        int c;
        int i;
        logic slow;
        logic [3:0] expBits;
        slow = (row.kind == KPotSlow);
        span = slow ? (PotMax + 1) * TickDiv : PotMax + 1;
        for (i = 0; i < 4; i++) begin
            rise[i] = row.arg[i] ? span + 10 : $urandom % span;
            lo[i]   = slow ? rise[i] / TickDiv : rise[i];
            lo[i]   = (lo[i] > PotMax) ? PotMax : lo[i];
            hi[i]   = (slow && lo[i] < PotMax) ? lo[i] + 1 : lo[i];
        end
        @(negedge clk179);
        potIn = 4'h0;
        regs.skctl[pokeyRegPkg::SkctlFastPot] = !slow;
        potGo = 1'b1;
        @(negedge clk179);
        potGo = 1'b0;
        u_pokeyControllerChecker.scanStatus(1'b0, 8'h0F);
        c = 0;
        while (!padOut.potRelease && c <= span + TickDiv) begin
            for (i = 0; i < 4; i++) begin
                expBits[i] = (rise[i] >= c);    // still counting
                potIn[i]   = (c >= rise[i]);
            end
            if (!slow) begin
                u_pokeyControllerChecker.expectByte("allpot", readBus.allpot, {4'h0, expBits});
            end
            @(negedge clk179);
            c++;
        end
        if (!padOut.potRelease) begin
            u_pokeyControllerChecker.reportStall("pot scan did not finish");
        end
        potIn = 4'h0;
        u_pokeyControllerChecker.scanStatus(1'b1, 8'h00);
        for (i = 0; i < 4; i++) begin
            u_pokeyControllerChecker.potInWindow(i, lo[i], hi[i]);
        end
    endtask

    initial begin
        void'($urandom(88));
        arstN    = 1'b0;
        regs     = '0;
        regs.skctl[pokeyRegPkg::SkctlKeyScan] = 1'b1;
        potGo    = 1'b0;
        timerEvt = 3'b000;
        sideButL = 4'hF;
        potIn    = 4'h0;
        keyHeld  = 1'b0;
        keyPos   = 4'h0;
        repeat (10) @(negedge clk179);
        arstN = 1'b1;
        for (int r = 0; r < NumRows; r++) begin
            case (stimTable[r].kind)
                KReset: begin
                    @(negedge clk179);
                    u_pokeyControllerChecker.irqstEquals(~stimTable[r].irqen);
                    u_pokeyControllerChecker.verifyKeypad(stimTable[r].expA, stimTable[r].expB);
                    u_pokeyControllerChecker.keyDriveIs(4'b1110);  // scan position 0
                    u_pokeyControllerChecker.scanStatus(1'b1, 8'h00);
                end
                KKey:    pressKey(stimTable[r]);
                KTrig:   exerciseTriggers(stimTable[r]);
                KIrq:    fireIrqSources(stimTable[r]);
                default: scanPots(stimTable[r]);
            endcase
            u_pokeyControllerChecker.closeRow(r, rowName(stimTable[r].kind));
        end
        u_pokeyControllerChecker.printSummary();
        if (u_pokeyControllerChecker.testsFailed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // every row may take as long as one slow pot scan
    initial begin
        #(NumRows * RowCycles * ClkPeriod);
        $display("ERROR: the run timed out before all table rows finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== sim/pokeyControllerChecker.sv ====
`timescale 1ns/1ps

module pokeyControllerChecker (
    input logic                 clk179,
    input logic                 arstN,
    input pokeyIoPkg::padOutT   padOut,
    input pokeyRegPkg::readBusT readBus,
    input logic                 irqL
);

    int rowErrors   = 0;
    int totalErrors = 0;
    int testsRun    = 0;
    int testsFailed = 0;

    task automatic expectByte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
            rowErrors++;
        end
    endtask

    task automatic reportStall(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        rowErrors++;
    endtask

    // irqL low exactly while some IRQST bit is pending
    always @(posedge clk179) begin
        if (arstN === 1'b1) begin
            expectByte("irqL", {7'd0, irqL}, {7'd0, readBus.irqst == 8'hFF});
            expectByte("irqst[5:3]", {5'd0, readBus.irqst[5:3]}, 8'h07);   // serial bits and bit 3
        end
    end

    task automatic irqstEquals(input logic [7:0] expIrqst);
        expectByte("irqst", readBus.irqst, expIrqst);
    endtask

    task automatic verifyKeypad(input logic [7:0] expKbcode, input logic [7:0] expSkstat);
        expectByte("kbcode", readBus.kbcode, expKbcode);
        expectByte("skstat", readBus.skstat, expSkstat);
    endtask

    task automatic keyDriveIs(input logic [3:0] expDrive);
        expectByte("keyDriveL", {4'd0, padOut.keyDriveL}, {4'd0, expDrive});
    endtask

    task automatic matchTriggers(input logic [7:0] exp0, input logic [7:0] exp1);
        expectByte("trig0", readBus.trig0, exp0);
        expectByte("trig1", readBus.trig1, exp1);
    endtask

    task automatic scanStatus(input logic expRelease, input logic [7:0] expAllpot);
        expectByte("potRelease", {7'd0, padOut.potRelease}, {7'd0, expRelease});
        expectByte("allpot", readBus.allpot, expAllpot);
    endtask

    // slow scans allow one tick of slack
    task automatic potInWindow(input int idx, input int lo, input int hi);
        logic [7:0] got;
        case (idx)
            0: got = readBus.pot0;
            1: got = readBus.pot1;
            2: got = readBus.pot2;
            default: got = readBus.pot3;
        endcase
        if (got < lo || got > hi) begin
            $display("FAILED at %0t ns: pot%0d read %0d, expected %0d to %0d",
                     $time, idx, got, lo, hi);
            rowErrors++;
        end
    endtask

    task automatic closeRow(input int row, input string name);
        testsRun++;
        totalErrors += rowErrors;
        if (rowErrors == 0) begin
            $display("test %0d (%s): ok", row, name);
        end else begin
            testsFailed++;
            $display("test %0d (%s): %0d errors", row, name, rowErrors);
        end
        rowErrors = 0;
    endtask

    task automatic printSummary();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, totalErrors);
    endtask

endmodule

// ==== verilog/pokeyControllerTop.sv ====
`timescale 1ns/1ps

module pokeyControllerTop (
    input  logic                  clk179,
    input  logic                  arstN,
    input  pokeyRegPkg::ctrlRegsT regs,
    input  pokeyIoPkg::padInT     padIn,
    input  logic                  potGo,
    input  logic [2:0]            timerEvt,    // {tim4, tim2, tim1}
    output wire pokeyIoPkg::padOutT   padOut,
    output wire pokeyRegPkg::readBusT readBus,
    output logic                  irqL
);

    logic keyEvt;
    logic breakEvt;

    keypadScanner u_keypadScanner (
        .clk179   (clk179),
        .arstN    (arstN),
        .scanEn   (regs.skctl[pokeyRegPkg::SkctlKeyScan]),
        .keyIn    (padIn.keyIn),
        .sideButL (padIn.sideButL),
        .keyDriveL(padOut.keyDriveL),
        .kbcode   (readBus.kbcode),
        .skstat   (readBus.skstat),
        .keyEvt   (keyEvt),
        .breakEvt (breakEvt)
    );

    potScanner u_potScanner (
        .clk179    (clk179),
        .arstN     (arstN),
        .potGo     (potGo),
        .fastMode  (regs.skctl[pokeyRegPkg::SkctlFastPot]),
        .potIn     (padIn.potIn),
        .potRelease(padOut.potRelease),
        .pot0      (readBus.pot0),
        .pot1      (readBus.pot1),
        .pot2      (readBus.pot2),
        .pot3      (readBus.pot3),
        .allpot    (readBus.allpot)
    );

    // bottom buttons are the triggers, {bot1, bot0}
    triggerLatch u_triggerLatch (
        .clk179 (clk179),
        .arstN  (arstN),
        .latchEn(regs.gractl[pokeyRegPkg::GractlTrigLatch]),
        .trigInL({padIn.sideButL[0], padIn.sideButL[2]}),
        .trig0  (readBus.trig0),
        .trig1  (readBus.trig1)
    );

    irqStatus u_irqStatus (
        .clk179  (clk179),
        .arstN   (arstN),
        .irqEn   (regs.irqen),
        .breakEvt(breakEvt),
        .keyEvt  (keyEvt),
        .timerEvt(timerEvt),
        .irqst   (readBus.irqst),
        .irqL    (irqL)
    );

endmodule

// ==== verilog/irqStatus.sv ====
`timescale 1ns/1ps

module irqStatus (
    input  logic       clk179,
    input  logic       arstN,
    input  logic [7:0] irqEn,
    input  logic       breakEvt,
    input  logic       keyEvt,
    input  logic [2:0] timerEvt,
    output logic [7:0] irqst,
    output logic       irqL
);

    localparam int NumSrc = 5;

    // source order {brk, key, tim4, tim2, tim1}
    logic [NumSrc-1:0] srcNow;
    logic [NumSrc-1:0] srcPrev;
    logic [NumSrc-1:0] srcRise;
    logic [NumSrc-1:0] srcEn;
    logic [NumSrc-1:0] stBits;     // 0 = pending
    logic [NumSrc-1:0] stOut;

    assign srcNow  = {breakEvt, keyEvt, timerEvt};
    assign srcEn   = {irqEn[pokeyRegPkg::IrqBrk],
                      irqEn[pokeyRegPkg::IrqKey],
                      irqEn[pokeyRegPkg::IrqTim4],
                      irqEn[pokeyRegPkg::IrqTim2],
                      irqEn[pokeyRegPkg::IrqTim1]};
    assign srcRise = srcNow & ~srcPrev;

    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            srcPrev <= '0;
            stBits  <= '1;
        end else begin
            srcPrev <= srcNow;
            stBits  <= ~srcEn | (stBits & ~(srcRise & srcEn));
        end
    end

    assign stOut = stBits | ~srcEn;     // masked bits read 1 at once

    always_comb begin
        irqst = 8'hFF;      // serial bits and bit 3 stay high
        irqst[pokeyRegPkg::IrqBrk]  = stOut[4];
        irqst[pokeyRegPkg::IrqKey]  = stOut[3];
        irqst[pokeyRegPkg::IrqTim4] = stOut[2];
        irqst[pokeyRegPkg::IrqTim2] = stOut[1];
        irqst[pokeyRegPkg::IrqTim1] = stOut[0];
    end

    assign irqL = &irqst;

endmodule

// ==== verilog/triggerLatch.sv ====
`timescale 1ns/1ps

module triggerLatch (
    input  logic       clk179,
    input  logic       arstN,
    input  logic       latchEn,
    input  logic [1:0] trigInL,
    output logic [7:0] trig0,
    output logic [7:0] trig1
);

    logic [1:0] pressed;
    logic [1:0] latchQ;     // sticky press per trigger
    logic [1:0] trigOn;

    assign pressed = ~trigInL;

    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            latchQ <= 2'b00;
        end else if (!latchEn) begin
            latchQ <= 2'b00;            // released by clearing the enable
        end else begin
            latchQ <= latchQ | pressed;
        end
    end

    // transparent unless latching is on
    assign trigOn = latchEn ? latchQ : pressed;

    assign trig0 = {7'b0000000, ~trigOn[0]};
    assign trig1 = {7'b0000000, ~trigOn[1]};

endmodule

// ==== verilog/potScanner.sv ====
`timescale 1ns/1ps

module potScanner (
    input  logic       clk179,
    input  logic       arstN,
    input  logic       potGo,
    input  logic       fastMode,
    input  logic [3:0] potIn,
    output logic       potRelease,
    output logic [7:0] pot0,
    output logic [7:0] pot1,
    output logic [7:0] pot2,
    output logic [7:0] pot3,
    output logic [7:0] allpot
);

    localparam int TickW = pokeyIoPkg::PotTickW;
    localparam int CntW  = pokeyIoPkg::PotCntW;

    logic [TickW-1:0]     tickCnt;
    logic                 tick;
    logic [CntW-1:0]      potCnt;       // shared count for all four lines
    logic                 atMax;
    logic [3:0]           pending;      // allpot bits
    logic [3:0]           latchNow;
    logic [3:0][CntW-1:0] potVal;

    assign tick = !potRelease &&
                  (fastMode || (tickCnt == TickW'(pokeyIoPkg::PotTickDiv - 1)));
    assign atMax = (potCnt == CntW'(pokeyIoPkg::PotMax));

    // at the end every pot still pending takes the last count
    assign latchNow = tick ? (pending & (potIn | {4{atMax}})) : 4'b0000;

    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            tickCnt <= '0;
        end else if (potGo || tick) begin
            tickCnt <= '0;
        end else if (!potRelease) begin
            tickCnt <= tickCnt + 1'b1;  // slow mode divider
        end
    end

    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            potCnt     <= '0;
            pending    <= 4'b0000;
            potVal     <= '0;
            potRelease <= 1'b1;     // pots dumped
        end else if (potGo) begin
            potCnt     <= '0;
            pending    <= 4'b1111;
            potVal     <= '0;
            potRelease <= 1'b0;     // let the caps charge
        end else if (tick) begin
            for (int i = 0; i < 4; i++) begin
                if (latchNow[i]) begin
                    potVal[i] <= potCnt;
                end
            end
            pending <= pending & ~latchNow;
            if (atMax) begin
                potRelease <= 1'b1;     // scan over
            end else begin
                potCnt <= potCnt + 1'b1;
            end
        end
    end

    assign pot0   = potVal[0];
    assign pot1   = potVal[1];
    assign pot2   = potVal[2];
    assign pot3   = potVal[3];
    assign allpot = {4'b0000, pending};

endmodule

// ==== verilog/keypadScanner.sv ====
`timescale 1ns/1ps

module keypadScanner (
    input  logic       clk179,
    input  logic       arstN,
    input  logic       scanEn,
    input  logic [3:0] keyIn,
    input  logic [3:0] sideButL,
    output logic [3:0] keyDriveL,
    output logic [7:0] kbcode,
    output logic [7:0] skstat,
    output logic       keyEvt,
    output logic       breakEvt
);

    localparam int DivW = pokeyIoPkg::KeyDivW;

    logic [DivW-1:0] divCnt;
    logic [3:0]      scanPos;
    logic            posEnd;        // last cycle of a position
    logic            retLine;       // selected return line
    logic            hitNow;
    logic            hitSeen;       // press already found this scan
    logic [3:0]      keycodeLatch;
    logic            keyValid;
    logic [7:0]      storedCode;
    logic            top0;
    logic            top1;

    assign top0 = ~sideButL[3];
    assign top1 = ~sideButL[1];

    assign posEnd  = scanEn && (divCnt == DivW'(pokeyIoPkg::KeyScanDiv - 1));
    assign retLine = keyIn[scanPos[1:0]];   // row select
    assign hitNow  = posEnd && !retLine;

    // column c goes low for position bits 3:2 == c
    assign keyDriveL = ~(4'b0001 << scanPos[3:2]);

    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            divCnt  <= '0;
            scanPos <= '0;
        end else if (scanEn) begin
            if (posEnd) begin
                divCnt  <= '0;
                scanPos <= scanPos + 4'd1;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

    // keycode latch, cleared by a scan with no press
    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            keycodeLatch <= '0;
            keyValid     <= 1'b0;
            hitSeen      <= 1'b0;
        end else if (posEnd) begin
            if (hitNow) begin
                keycodeLatch <= scanPos;
                keyValid     <= 1'b1;
            end
            if (scanPos == 4'hF) begin
                hitSeen <= 1'b0;    // new scan starts
                if (!hitSeen && !hitNow) begin
                    keycodeLatch <= '0;
                    keyValid     <= 1'b0;
                end
            end else if (hitNow) begin
                hitSeen <= 1'b1;
            end
        end
    end

    always_comb begin
        kbcode = 8'h00;
        if (keyValid) begin
            kbcode[7:6] = top0 ? 2'b00 : 2'b11;
            kbcode[4:1] = pokeyRegPkg::kbMapLookup(keycodeLatch);
        end
    end

    assign skstat   = top0 ? 8'h09 : 8'h01;
    assign breakEvt = top0 | top1;

    // one pulse per new nonzero code
    always_ff @(posedge clk179 or negedge arstN) begin
        if (!arstN) begin
            storedCode <= 8'h00;
            keyEvt     <= 1'b0;
        end else if ((kbcode != 8'h00) && (kbcode != storedCode)) begin
            storedCode <= kbcode;
            keyEvt     <= 1'b1;
        end else begin
            keyEvt <= 1'b0;
        end
    end

endmodule

// ==== verilog/pokeyIoPkg.sv ====
package pokeyIoPkg;

    // pins coming in from the controller port
    typedef struct packed {
        logic [3:0] keyIn;      // keypad return lines, active low
        logic [3:0] sideButL;   // {top0, bot0, top1, bot1}
        logic [3:0] potIn;      // pot comparator outputs
    } padInT;

    // pins going out to the controller port
    typedef struct packed {
        logic [3:0] keyDriveL;  // column selects, active low
        logic       potRelease; // 1 dumps the pot capacitors
    } padOutT;

    // keypad scan rate
    localparam int KeyScanDiv = 64;                 // cycles per scan position
    localparam int KeyDivW    = $clog2(KeyScanDiv);

    // pot scan rate and range
    localparam int PotTickDiv = 114;                // cycles per slow tick
    localparam int PotTickW   = $clog2(PotTickDiv);
    localparam int PotMax     = 228;                // last count of a scan
    localparam int PotCntW    = 8;

endpackage

// ==== verilog/pokeyRegPkg.sv ====
package pokeyRegPkg;

    // control registers as written by the CPU
    typedef struct packed {
        logic [7:0] skctl;
        logic [7:0] gractl;
        logic [7:0] irqen;
    } ctrlRegsT;

    // values the CPU would read back
    typedef struct packed {
        logic [7:0] irqst;
        logic [7:0] pot0;
        logic [7:0] pot1;
        logic [7:0] pot2;
        logic [7:0] pot3;
        logic [7:0] allpot;
        logic [7:0] kbcode;
        logic [7:0] skstat;
        logic [7:0] trig0;
        logic [7:0] trig1;
    } readBusT;

    localparam int IrqBrk  = 7;         // break key, top buttons
    localparam int IrqKey  = 6;         // keyboard code change
    localparam int IrqTim1 = 0;
    localparam int IrqTim2 = 1;
    localparam int IrqTim4 = 2;

    localparam int SkctlKeyScan    = 1; // keypad scan enable
    localparam int SkctlFastPot    = 2; // pot scan at full rate
    localparam int GractlTrigLatch = 2; // trigger latch enable

    // scan position to KBCODE bits 4:1
    function automatic logic [3:0] kbMapLookup(input logic [3:0] keycode);
        logic [3:0] code;
        case (keycode)
            4'h0: code = 4'b0000;
            4'h1: code = 4'b0011;
            4'h2: code = 4'b0010;
            4'h3: code = 4'b0001;
            4'h4: code = 4'b1100;
            4'h5: code = 4'b1111;
            4'h6: code = 4'b1110;
            4'h7: code = 4'b1101;
            4'h8: code = 4'b1000;
            4'h9: code = 4'b1011;
            4'hA: code = 4'b1010;
            4'hB: code = 4'b1001;
            4'hC: code = 4'b0100;
            4'hD: code = 4'b0111;
            4'hE: code = 4'b0110;
            default: code = 4'b0101;    // position F
        endcase
        return code;
    endfunction

endpackage
